//--- flist.f
+incdir+rtl
rtl/datapathPkg.sv
rtl/busMux.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/memoryInterface.sv
rtl/controlRegs.sv
rtl/cpuDatapath.sv
tests/datapathTb.sv

//--- rtl/alu.sv
`timescale 1ns/1ps
`include "datapath_defines.svh"

module alu (
    input  datapathPkg::word_t   a,       // Y register
    input  datapathPkg::word_t   b,       // bus
    input  datapathPkg::aluOp_t  opcode,
    output datapathPkg::dword_t  result
);
    import datapathPkg::*;

    localparam int Width = `DATA_WIDTH;
    localparam int AmtWidth = $clog2(Width);

    logic [AmtWidth-1:0]        amount;
    logic [2*Width-1:0]         rorWide;
    logic [2*Width-1:0]         rolWide;
    logic signed [2*Width-1:0]  product;
    logic signed [2*Width-1:0]  dividend;
    logic signed [2*Width-1:0]  divisor;
    logic signed [2*Width-1:0]  quotient;
    logic signed [2*Width-1:0]  remainder;
    word_t                      low;
    word_t                      high;

    assign amount = b[AmtWidth-1:0];  // shift count from the low bits of the bus

    // rotates taken from a doubled copy of the word
    assign rorWide = {a, a} >> amount;
    assign rolWide = {a, a} << amount;

    assign product = (2*Width)'($signed(a)) * (2*Width)'($signed(b));

    // divide at double width so the most negative word over -1 cannot overflow
    assign dividend = {{Width{a[Width-1]}}, a};
    assign divisor = {{Width{b[Width-1]}}, b};
    assign quotient = (b == '0) ? $signed({(2*Width){1'b1}}) : dividend / divisor;
    assign remainder = (b == '0) ? dividend : dividend % divisor;

    always_comb begin
        low = '0;
        high = '0;
        case (opcode)
            opAdd:   low = a + b;
            opSub:   low = a - b;
            opAnd:   low = a & b;
            opOr:    low = a | b;
            opShr:   low = a >> amount;
            opShra:  low = $signed(a) >>> amount;
            opShl:   low = a << amount;
            opRor:   low = rorWide[Width-1:0];
            opRol:   low = rolWide[2*Width-1:Width];
            opMul: begin
                low = product[Width-1:0];
                high = product[2*Width-1:Width];
            end
            opDiv: begin
                low = quotient[Width-1:0];    // quotient to LO side
                high = remainder[Width-1:0];  // remainder to HI side
            end
            opNeg:   low = -b;  // unary ops act on the bus operand
            opNot:   low = ~b;
            default: low = '0;
        endcase
        result = {high, low};
    end

endmodule

//--- rtl/busMux.sv
`timescale 1ns/1ps
`include "datapath_defines.svh"

module busMux (
    input  logic [`REG_COUNT-1:0]                  regOut,
    input  logic                                   hiOut,
    input  logic                                   loOut,
    input  logic                                   zHighOut,
    input  logic                                   zLowOut,
    input  logic                                   pcOut,
    input  logic                                   mdrOut,
    input  logic                                   inPortOut,
    input  logic                                   cOut,
    input  datapathPkg::word_t [`REG_COUNT-1:0]    regData,
    input  datapathPkg::word_t                     hi,
    input  datapathPkg::word_t                     lo,
    input  datapathPkg::word_t                     zHigh,
    input  datapathPkg::word_t                     zLow,
    input  datapathPkg::word_t                     pc,
    input  datapathPkg::word_t                     mdr,
    input  datapathPkg::word_t                     inPortData,
    input  datapathPkg::word_t                     cValue,
    output datapathPkg::word_t                     bus
);
    import datapathPkg::*;

    localparam int RegCount = `REG_COUNT;
    localparam int SelW = `REG_SEL_WIDTH;

    busSrc_t               src;
    logic [SelW-1:0]       regIdx;

    // fixed priority, lowest general register first
    always_comb begin
        src = srcNone;
        regIdx = '0;
        if (|regOut) begin
            src = srcReg;
            for (int i = RegCount - 1; i >= 0; i--) begin
                if (regOut[i]) begin
                    regIdx = SelW'(i);  // last hit is the lowest index
                end
            end
        end else if (hiOut) begin
            src = srcHi;
        end else if (loOut) begin
            src = srcLo;
        end else if (zHighOut) begin
            src = srcZHigh;
        end else if (zLowOut) begin
            src = srcZLow;
        end else if (pcOut) begin
            src = srcPc;
        end else if (mdrOut) begin
            src = srcMdr;
        end else if (inPortOut) begin
            src = srcInPort;
        end else if (cOut) begin
            src = srcConst;
        end
    end

    always_comb begin
        case (src)
            srcReg:    bus = regData[regIdx];
            srcHi:     bus = hi;
            srcLo:     bus = lo;
            srcZHigh:  bus = zHigh;
            srcZLow:   bus = zLow;
            srcPc:     bus = pc;
            srcMdr:    bus = mdr;
            srcInPort: bus = inPortData;
            srcConst:  bus = cValue;
            default:   bus = '0;  // idle bus reads as zero
        endcase
    end

endmodule

//--- rtl/controlRegs.sv
`timescale 1ns/1ps
`include "datapath_defines.svh"

module controlRegs (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 pcEnable,
    input  logic                 incPc,
    input  logic                 irEnable,
    input  logic                 yEnable,
    input  logic                 zEnable,
    input  logic                 hiEnable,
    input  logic                 loEnable,
    input  datapathPkg::word_t   bus,
    input  datapathPkg::dword_t  aluResult,
    output datapathPkg::word_t   pc,
    output datapathPkg::word_t   ir,
    output datapathPkg::word_t   y,
    output datapathPkg::word_t   zHigh,
    output datapathPkg::word_t   zLow,
    output datapathPkg::word_t   hi,
    output datapathPkg::word_t   lo,
    output datapathPkg::word_t   cValue
);
    import datapathPkg::*;

    localparam int Width = `DATA_WIDTH;
    localparam int ConstWidth = 19;  // immediate field of IR

    dword_t zReg;
    word_t  pcNext;

    assign pcNext = incPc ? pc + word_t'(1) : bus;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
            ir <= '0;
            y <= '0;
            zReg <= '0;
            hi <= '0;
            lo <= '0;
        end else begin
            if (pcEnable) begin
                pc <= pcNext;
            end
            if (irEnable) begin
                ir <= bus;
            end
            if (yEnable) begin
                y <= bus;
            end
            if (zEnable) begin
                zReg <= aluResult;  // Z is the only register fed by the ALU
            end
            if (hiEnable) begin
                hi <= bus;
            end
            if (loEnable) begin
                lo <= bus;
            end
        end
    end

    assign zHigh = zReg[2*Width-1:Width];
    assign zLow = zReg[Width-1:0];

    assign cValue = {{(Width - ConstWidth){ir[ConstWidth-1]}}, ir[ConstWidth-1:0]};

endmodule

//--- rtl/cpuDatapath.sv
`timescale 1ns/1ps
`include "datapath_defines.svh"

module cpuDatapath (
    input  logic                   Clock,
    input  logic                   rstN,
    input  logic [`REG_COUNT-1:0]  regOut,
    input  logic                   hiOut,
    input  logic                   loOut,
    input  logic                   zHighOut,
    input  logic                   zLowOut,
    input  logic                   pcOut,
    input  logic                   mdrOut,
    input  logic                   inPortOut,
    input  logic                   cOut,
    input  logic [`REG_COUNT-1:0]  regEnable,
    input  logic                   pcEnable,
    input  logic                   irEnable,
    input  logic                   yEnable,
    input  logic                   zEnable,
    input  logic                   hiEnable,
    input  logic                   loEnable,
    input  logic                   mdrEnable,
    input  logic                   marEnable,
    input  logic                   read,
    input  logic                   incPc,
    input  datapathPkg::aluOp_t    opcode,
    input  datapathPkg::word_t     memDataIn,
    input  datapathPkg::word_t     inPortData,
    output datapathPkg::word_t     busValue,
    output datapathPkg::word_t     marValue
);
    import datapathPkg::*;

    word_t                  bus;
    word_t [`REG_COUNT-1:0] regData;
    word_t                  pc;
    word_t                  y;
    word_t                  zHigh;
    word_t                  zLow;
    word_t                  hi;
    word_t                  lo;
    word_t                  mdr;
    word_t                  cValue;
    dword_t                 aluResult;

    busMux i_busMux (
        .regOut     (regOut),
        .hiOut      (hiOut),
        .loOut      (loOut),
        .zHighOut   (zHighOut),
        .zLowOut    (zLowOut),
        .pcOut      (pcOut),
        .mdrOut     (mdrOut),
        .inPortOut  (inPortOut),
        .cOut       (cOut),
        .regData    (regData),
        .hi         (hi),
        .lo         (lo),
        .zHigh      (zHigh),
        .zLow       (zLow),
        .pc         (pc),
        .mdr        (mdr),
        .inPortData (inPortData),
        .cValue     (cValue),
        .bus        (bus)
    );

    registerFile i_registerFile (
        .Clock      (Clock),
        .rstN       (rstN),
        .regEnable  (regEnable),
        .bus        (bus),
        .regData    (regData)
    );

    alu i_alu (
        .a          (y),
        .b          (bus),
        .opcode     (opcode),
        .result     (aluResult)
    );

    memoryInterface i_memoryInterface (
        .Clock      (Clock),
        .rstN       (rstN),
        .mdrEnable  (mdrEnable),
        .marEnable  (marEnable),
        .read       (read),
        .memDataIn  (memDataIn),
        .bus        (bus),
        .mdr        (mdr),
        .mar        (marValue)
    );

    controlRegs i_controlRegs (
        .Clock      (Clock),
        .rstN       (rstN),
        .pcEnable   (pcEnable),
        .incPc      (incPc),
        .irEnable   (irEnable),
        .yEnable    (yEnable),
        .zEnable    (zEnable),
        .hiEnable   (hiEnable),
        .loEnable   (loEnable),
        .bus        (bus),
        .aluResult  (aluResult),
        .pc         (pc),
        .ir         (),  // IR only feeds the C constant, no decoder here
        .y          (y),
        .zHigh      (zHigh),
        .zLow       (zLow),
        .hi         (hi),
        .lo         (lo),
        .cValue     (cValue)
    );

    assign busValue = bus;

endmodule

//--- rtl/datapathPkg.sv
`include "datapath_defines.svh"

package datapathPkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [2*`DATA_WIDTH-1:0] dword_t;  // Z holds the full ALU result

    typedef enum logic [4:0] {
        opAdd   = 5'b00011,
        opSub   = 5'b00100,
        opShr   = 5'b00101,  // logical
        opShra  = 5'b00110,  // arithmetic
        opShl   = 5'b00111,
        opRor   = 5'b01000,
        opRol   = 5'b01001,
        opAnd   = 5'b01010,
        opOr    = 5'b01011,
        opMul   = 5'b01111,  // signed
        opDiv   = 5'b10000,  // signed
        opNeg   = 5'b10001,
        opNot   = 5'b10010
    } aluOp_t;

    typedef enum logic [3:0] {
        srcReg,
        srcHi,
        srcLo,
        srcZHigh,
        srcZLow,
        srcPc,
        srcMdr,
        srcInPort,
        srcConst,
        srcNone
    } busSrc_t;

endpackage

//--- rtl/datapath_defines.svh
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// machine word carried by the bus and every register
`define DATA_WIDTH 32

// general registers R0 to R15
`define REG_COUNT 16

// index width for the general register bank
`define REG_SEL_WIDTH 4

`endif

//--- rtl/memoryInterface.sv
`timescale 1ns/1ps

module memoryInterface (
    input  logic                Clock,
    input  logic                rstN,
    input  logic                mdrEnable,
    input  logic                marEnable,
    input  logic                read,
    input  datapathPkg::word_t  memDataIn,
    input  datapathPkg::word_t  bus,
    output datapathPkg::word_t  mdr,
    output datapathPkg::word_t  mar
);
    import datapathPkg::*;

    word_t mdrIn;

    assign mdrIn = read ? memDataIn : bus;  // memory read or write-back from the bus

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            mdr <= '0;
        end else if (mdrEnable) begin
            mdr <= mdrIn;
        end
    end

    // address only leaves the datapath, nothing reads it back
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            mar <= '0;
        end else if (marEnable) begin
            mar <= bus;
        end
    end

endmodule

//--- rtl/registerFile.sv
`timescale 1ns/1ps
`include "datapath_defines.svh"

module registerFile (
    input  logic                                   Clock,
    input  logic                                   rstN,
    input  logic [`REG_COUNT-1:0]                  regEnable,
    input  datapathPkg::word_t                     bus,
    output datapathPkg::word_t [`REG_COUNT-1:0]    regData
);

    localparam int RegCount = `REG_COUNT;

    // each register has its own load strobe, several may load at once
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            regData <= '0;
        end else begin
            for (int i = 0; i < RegCount; i++) begin
                if (regEnable[i]) begin
                    regData[i] <= bus;
                end
            end
        end
    end

endmodule

//--- runSim.sh
#!/bin/sh
# build and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module datapathTb -o datapathSim

output=$(./obj_dir/datapathSim)
echo "$output"

if echo "$output" | grep -q "TEST PASS"; then
    exit 0
fi
exit 1

//--- tests/datapathTb.sv
`timescale 1ns/1ps
`include "datapath_defines.svh"

module datapathTb;
    import datapathPkg::*;

    localparam int ClkPeriod = 8;
    localparam int ResetCycles = 4;
    localparam int NumRandom = 6;
    localparam int SelHi = 16;  // source and target codes above the general registers
    localparam int SelLo = 17;
    localparam int SelZHigh = 18;
    localparam int SelZLow = 19;
    localparam int SelPc = 20;
    localparam int SelMdr = 21;
    localparam int SelInPort = 22;
    localparam int SelConst = 23;
    localparam int SelY = 24;
    localparam int SelIr = 25;
    localparam int SelNone = 26;
    // ten steps per division, eight per other operation, the rest for loads and fetch
    localparam int StepBudget = (2 + NumRandom) * 10 + 12 * NumRandom * 8 + 110;
    localparam int TimeoutNs = (StepBudget + ResetCycles + 50) * ClkPeriod;

    logic Clock;
    logic rstN;
    logic [`REG_COUNT-1:0] regOut;
    logic [`REG_COUNT-1:0] regEnable;
    logic hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut;
    logic pcEnable, irEnable, yEnable, zEnable, hiEnable, loEnable, mdrEnable, marEnable;
    logic read;
    logic incPc;
    aluOp_t opcode;
    word_t memDataIn, inPortData, busValue, marValue;
    logic checkValid;
    logic checkMar;     // compare MAR instead of the bus
    word_t expValue;
    word_t actualValue;
    string testName;
    int passCount;
    int errorCount;
    integer seed;

    cpuDatapath i_cpuDatapath (.*);

    initial begin
        Clock = 1'b0;
        forever #(ClkPeriod / 2) Clock = ~Clock;
    end

    // expected ALU result for Y in a and the bus in b
    function automatic dword_t refAlu(aluOp_t op, word_t a, word_t b);
        int n;
        longint sa;
        longint sb;
        longint q;
        longint r;
        word_t lowPart;
        word_t highPart;
        n = int'(b[4:0]);
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        lowPart = '0;
        highPart = '0;
        case (op)
            opAdd:  lowPart = a + b;
            opSub:  lowPart = a - b;
            opAnd:  lowPart = a & b;
            opOr:   lowPart = a | b;
            opShr:  lowPart = a >> n;
            opShra: lowPart = word_t'($signed(a) >>> n);
            opShl:  lowPart = a << n;
            opRor:  lowPart = (a >> n) | (a << (32 - n));
            opRol:  lowPart = (a << n) | (a >> (32 - n));
            opNeg:  lowPart = 32'd0 - b;
            opNot:  lowPart = ~b;
            opMul: begin
                q = sa * sb;
                {highPart, lowPart} = q;
            end
            opDiv: begin
                if (b == '0) begin
                    lowPart = '1;
                    highPart = a;
                end else begin
                    q = sa / sb;
                    r = sa % sb;
                    lowPart = q[31:0];
                    highPart = r[31:0];
                end
            end
            default: lowPart = '0;
        endcase
        return {highPart, lowPart};
    endfunction

    task automatic idle();
        regOut = '0;
        regEnable = '0;
        {hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut} = '0;
        {pcEnable, irEnable, yEnable, zEnable, hiEnable, loEnable, mdrEnable, marEnable} = '0;
        read = 1'b0;
        incPc = 1'b0;
        opcode = opAdd;
        checkValid = 1'b0;
        checkMar = 1'b0;
    endtask

    task automatic nextStep();
        @(posedge Clock);
        #1 idle();
    endtask

    task automatic driveOut(int code);
        if (code < `REG_COUNT) begin
            regOut[code[3:0]] = 1'b1;
        end
        case (code)
            SelHi:     hiOut = 1'b1;
            SelLo:     loOut = 1'b1;
            SelZHigh:  zHighOut = 1'b1;
            SelZLow:   zLowOut = 1'b1;
            SelPc:     pcOut = 1'b1;
            SelMdr:    mdrOut = 1'b1;
            SelInPort: inPortOut = 1'b1;
            SelConst:  cOut = 1'b1;
            default:   ;
        endcase
    endtask

    task automatic driveEnable(int code);
        if (code < `REG_COUNT) begin
            regEnable[code[3:0]] = 1'b1;
        end
        case (code)
            SelHi:   hiEnable = 1'b1;
            SelLo:   loEnable = 1'b1;
            SelPc:   pcEnable = 1'b1;
            SelY:    yEnable = 1'b1;
            SelIr:   irEnable = 1'b1;
            default: ;
        endcase
    endtask

    task automatic transfer(int src, int dst);
        nextStep();
        driveOut(src);
        driveEnable(dst);
    endtask

    task automatic loadValue(int dst, word_t value);
        nextStep();
        read = 1'b1;  // memory word into MDR, then MDR onto the bus
        mdrEnable = 1'b1;
        memDataIn = value;
        transfer(SelMdr, dst);
    endtask

    task automatic aluStep(int src, aluOp_t op);
        nextStep();
        driveOut(src);
        opcode = op;
        zEnable = 1'b1;
    endtask

    task automatic readBus(string name, int src, word_t expected);
        nextStep();
        driveOut(src);
        testName = name;
        expValue = expected;
        checkValid = 1'b1;
    endtask

    task automatic checkMarValue(string name, word_t expected);
        nextStep();
        testName = name;
        expValue = expected;
        checkMar = 1'b1;
        checkValid = 1'b1;
    endtask

    task automatic runOp(string name, aluOp_t op, word_t a, word_t b);
        dword_t expected;
        expected = refAlu(op, a, b);
        loadValue(6, a);
        loadValue(7, b);
        transfer(6, SelY);
        aluStep(7, op);
        if (op == opDiv) begin
            transfer(SelZLow, SelLo);  // quotient to LO, remainder to HI
            transfer(SelZHigh, SelHi);
            readBus({name, " LO"}, SelLo, expected[31:0]);
            readBus({name, " HI"}, SelHi, expected[63:32]);
        end else begin
            readBus({name, " ZLow"}, SelZLow, expected[31:0]);
            readBus({name, " ZHigh"}, SelZHigh, expected[63:32]);
        end
    endtask

    always @(posedge Clock) begin
        if (checkValid) begin
            actualValue = checkMar ? marValue : busValue;
            if (actualValue !== expValue) begin
                $display("MISMATCH %s expected %h actual %h", testName, expValue, actualValue);
                errorCount++;
            end else begin
                $display("pass %s value %h", testName, actualValue);
                passCount++;
            end
        end
    end

    initial begin
        #(TimeoutNs);
        $display("timeout after %0d ns, the test sequence did not finish", TimeoutNs);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        word_t values [32];
        word_t a;
        word_t b;
        word_t oldPc;
        word_t irWord;
        aluOp_t op;
        seed = 32'h43566dee;
        passCount = 0;
        errorCount = 0;
        testName = "";
        expValue = '0;
        actualValue = '0;
        memDataIn = '0;
        inPortData = '0;
        rstN = 1'b0;
        idle();
        repeat (ResetCycles) @(posedge Clock);
        #1 rstN = 1'b1;

        for (int i = 0; i <= SelZLow; i++) begin
            readBus($sformatf("reset source %0d", i), i, '0);
        end
        checkMarValue("reset MAR", '0);
        for (int i = 0; i <= SelLo; i++) begin
            values[i[4:0]] = $random(seed);
            loadValue(i, values[i[4:0]]);
        end
        for (int i = 0; i <= SelLo; i++) begin
            readBus($sformatf("load source %0d", i), i, values[i[4:0]]);
        end

        runOp("div 2/2", opDiv, 32'd2, 32'd2);
        for (int i = 0; i < NumRandom; i++) begin
            a = $random(seed);
            b = $random(seed);
            runOp($sformatf("div random %0d", i), opDiv, a, b);
        end
        a = $random(seed);
        runOp("div by zero", opDiv, a, '0);

        op = op.first();
        do begin
            if (op != opDiv) begin
                for (int i = 0; i < NumRandom; i++) begin
                    a = $random(seed);
                    b = $random(seed);
                    runOp($sformatf("%s %0d", op.name(), i), op, a, b);
                end
            end
            op = op.next();
        end while (op != op.first());

        oldPc = $random(seed);
        loadValue(SelPc, oldPc);
        nextStep();
        driveOut(SelPc);  // fetch step moves the old PC to MAR while PC counts up
        marEnable = 1'b1;
        incPc = 1'b1;
        pcEnable = 1'b1;
        checkMarValue("fetch MAR", oldPc);
        readBus("fetch PC increment", SelPc, oldPc + 32'd1);
        for (int i = 0; i < 2; i++) begin
            irWord = $random(seed);
            irWord[18] = i[0];  // both signs of the constant
            loadValue(SelIr, irWord);
            readBus($sformatf("C constant %0d", i), SelConst, {{13{irWord[18]}}, irWord[18:0]});
        end

        a = $random(seed);
        b = $random(seed);
        loadValue(4, a);
        loadValue(9, b);
        readBus("priority R4 over R9", 4, a);
        regOut[9] = 1'b1;
        readBus("no source", SelNone, '0);
        inPortData = $random(seed);
        readBus("input port", SelInPort, inPortData);
        nextStep();

        $display("checks passed %0d, failed %0d", passCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
